// ==== Makefile ====
SIM        ?= verilator
TOP        ?= mem_subsys_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RUN_FLAGS  ?= +verilator+error+limit+100
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
src/bus_pkg.sv
src/spram_pkg.sv
src/spram_macro_model.sv
src/spram_wb32.sv
src/bus_addr_decode.sv
src/mem_regs.sv
src/bus_resp_mux.sv
src/mem_subsys_top.sv
tests/mem_subsys_chk.sv
tests/mem_subsys_tb.sv

// ==== src/bus_addr_decode.sv ====
module bus_addr_decode
    import bus_pkg::*;
(
    input  logic     stb,
    input  wb_addr_t adr,
    output logic     spram_stb,
    output logic     reg_stb
);

    logic reg_region;

    // upper half of the word space is the register block
    assign reg_region = adr[REGION_BIT];

    assign spram_stb = stb && !reg_region;
    assign reg_stb   = stb && reg_region;

endmodule

// ==== src/bus_pkg.sv ====
package bus_pkg;

    // word address from the master, bit 15 picks the register block
    typedef logic [15:0] wb_addr_t;

    typedef logic [31:0] wb_data_t;

    typedef logic [3:0]  wb_sel_t;   // one select per byte lane

    localparam int REGION_BIT = 15;

    typedef logic [1:0]  reg_idx_t;

    // register map inside the block, taken from adr[1:0]
    localparam reg_idx_t REG_ID       = 2'd0;
    localparam reg_idx_t REG_SCRATCH  = 2'd1;
    localparam reg_idx_t REG_WR_COUNT = 2'd2;
    localparam reg_idx_t REG_RD_COUNT = 2'd3;

    // "SP" tag followed by the size in KiB
    localparam wb_data_t ID_VALUE = 32'h5350_0128;

endpackage

// ==== src/bus_resp_mux.sv ====
module bus_resp_mux
    import bus_pkg::*;
(
    input  logic     I_wb_clk,
    input  logic     rst_n,
    input  logic     spram_stb,
    input  logic     reg_stb,
    input  wb_data_t spram_rdat,
    input  wb_data_t reg_rdat,
    input  logic     spram_ack,
    input  logic     reg_ack,
    output wb_data_t rdat,
    output logic     ack
);

    logic reg_sel_q;   // set while the register block owns the response

    // updated at the same edge the target registers its ack
    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            reg_sel_q <= 1'b0;
        end else if (spram_stb || reg_stb) begin
            reg_sel_q <= reg_stb;
        end
    end

    assign ack  = reg_sel_q ? reg_ack  : spram_ack;
    assign rdat = reg_sel_q ? reg_rdat : spram_rdat;

endmodule

// ==== src/mem_regs.sv ====
module mem_regs
    import bus_pkg::*;
(
    input  logic     I_wb_clk,
    input  logic     rst_n,
    input  logic     stb,
    input  logic     we,
    input  reg_idx_t idx,
    input  wb_sel_t  sel,
    input  wb_data_t wdat,
    input  logic     spram_stb,
    input  logic     spram_ack,
    output wb_data_t rdat,
    output logic     ack
);

    wb_data_t scratch;
    wb_data_t wr_count;
    wb_data_t rd_count;
    logic     scratch_wr;
    logic     spram_done;

    assign scratch_wr = stb && we && (idx == REG_SCRATCH);
    assign spram_done = spram_stb && spram_ack;   // true once per completed access

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (scratch_wr) begin
            for (int i = 0; i < $bits(wb_sel_t); i++) begin
                if (sel[i]) begin
                    scratch[i*8 +: 8] <= wdat[i*8 +: 8];
                end
            end
        end
    end

    // both counters wrap at 2^32
    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            wr_count <= '0;
            rd_count <= '0;
        end else if (spram_done) begin
            if (we) begin
                wr_count <= wr_count + 32'd1;
            end else begin
                rd_count <= rd_count + 32'd1;
            end
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (stb) begin
            case (idx)
                REG_ID:       rdat <= ID_VALUE;
                REG_SCRATCH:  rdat <= scratch;
                REG_WR_COUNT: rdat <= wr_count;
                REG_RD_COUNT: rdat <= rd_count;
                default:      rdat <= '0;
            endcase
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= stb;
        end
    end

endmodule

// ==== src/mem_subsys_top.sv ====
module mem_subsys_top
    import bus_pkg::*;
    import spram_pkg::*;
(
    input  logic     I_wb_clk,
    input  logic     rst_n,
    input  logic     stb,
    input  logic     we,
    input  wb_addr_t adr,
    input  wb_sel_t  sel,
    input  wb_data_t wdat,
    output wb_data_t rdat,
    output logic     ack
);

    logic             spram_stb;
    logic             reg_stb;
    logic             spram_ack;
    logic             reg_ack;
    wb_data_t         spram_rdat;
    wb_data_t         reg_rdat;
    spram_word_addr_t spram_adr;
    reg_idx_t         reg_idx;

    assign spram_adr = adr[$bits(spram_word_addr_t)-1:0];
    assign reg_idx   = adr[$bits(reg_idx_t)-1:0];

    bus_addr_decode i_bus_addr_decode (
        .stb       (stb),
        .adr       (adr),
        .spram_stb (spram_stb),
        .reg_stb   (reg_stb)
    );

    spram_wb32 i_spram_wb32 (
        .I_wb_clk (I_wb_clk),
        .rst_n    (rst_n),
        .stb      (spram_stb),
        .we       (we),
        .adr      (spram_adr),
        .sel      (sel),
        .wdat     (wdat),
        .rdat     (spram_rdat),
        .ack      (spram_ack)
    );

    mem_regs i_mem_regs (
        .I_wb_clk  (I_wb_clk),
        .rst_n     (rst_n),
        .stb       (reg_stb),
        .we        (we),
        .idx       (reg_idx),
        .sel       (sel),
        .wdat      (wdat),
        .spram_stb (spram_stb),
        .spram_ack (spram_ack),
        .rdat      (reg_rdat),
        .ack       (reg_ack)
    );

    bus_resp_mux i_bus_resp_mux (
        .I_wb_clk   (I_wb_clk),
        .rst_n      (rst_n),
        .spram_stb  (spram_stb),
        .reg_stb    (reg_stb),
        .spram_rdat (spram_rdat),
        .reg_rdat   (reg_rdat),
        .spram_ack  (spram_ack),
        .reg_ack    (reg_ack),
        .rdat       (rdat),
        .ack        (ack)
    );

endmodule

// ==== src/spram_macro_model.sv ====
module spram_macro_model
    import spram_pkg::*;
(
    input  logic        I_wb_clk,
    input  spram_addr_t addr,
    input  spram_word_t din,
    input  spram_mask_t mask,
    input  logic        wren,
    input  logic        cs,
    output spram_word_t dout
);

    localparam int DEPTH  = 2 ** $bits(spram_addr_t);
    localparam int NIBBLE = 4;

    spram_word_t mem [DEPTH];

    // standby, sleep and power-off are not modelled, the array is always on

    always_ff @(posedge I_wb_clk) begin
        if (cs) begin
            if (wren) begin
                // dout holds its last value during a write
                for (int n = 0; n < $bits(spram_mask_t); n++) begin
                    if (mask[n]) begin
                        mem[addr][n*NIBBLE +: NIBBLE] <= din[n*NIBBLE +: NIBBLE];
                    end
                end
            end else begin
                dout <= mem[addr];   // registered read
            end
        end
    end

endmodule

// ==== src/spram_pkg.sv ====
package spram_pkg;

    // one macro is 16K words of 16 bits
    typedef logic [13:0] spram_addr_t;

    typedef logic [15:0] spram_word_t;

    // one write enable per nibble
    typedef logic [3:0]  spram_mask_t;

    // each bank pairs two macros into a 32-bit word
    localparam int BANK_COUNT = 2;

    // word address inside the SPRAM region
    // top bit picks the bank, the rest goes to the macros
    typedef logic [14:0] spram_word_addr_t;

endpackage

// ==== src/spram_wb32.sv ====
module spram_wb32
    import bus_pkg::*;
    import spram_pkg::*;
(
    input  logic             I_wb_clk,
    input  logic             rst_n,
    input  logic             stb,
    input  logic             we,
    input  spram_word_addr_t adr,
    input  wb_sel_t          sel,
    input  wb_data_t         wdat,
    output wb_data_t         rdat,
    output logic             ack
);

    localparam int BANK_BIT = $bits(spram_word_addr_t) - 1;

    logic        bank;
    logic        bank_q;
    logic        write;
    spram_addr_t macro_addr;
    spram_mask_t mask_lo;
    spram_mask_t mask_hi;
    spram_word_t dout_lo [BANK_COUNT];
    spram_word_t dout_hi [BANK_COUNT];

    assign bank       = adr[BANK_BIT];
    assign macro_addr = adr[BANK_BIT-1:0];
    assign write      = stb && we;

    // each byte select enables both nibbles of its byte
    assign mask_lo = {sel[1], sel[1], sel[0], sel[0]};
    assign mask_hi = {sel[3], sel[3], sel[2], sel[2]};

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        logic bank_cs;

        assign bank_cs = stb && (bank == 1'(b));

        spram_macro_model i_lo (
            .I_wb_clk (I_wb_clk),
            .addr     (macro_addr),
            .din      (wdat[15:0]),
            .mask     (mask_lo),
            .wren     (write),
            .cs       (bank_cs),
            .dout     (dout_lo[b])
        );

        spram_macro_model i_hi (
            .I_wb_clk (I_wb_clk),
            .addr     (macro_addr),
            .din      (wdat[31:16]),
            .mask     (mask_hi),
            .wren     (write),
            .cs       (bank_cs),
            .dout     (dout_hi[b])
        );
    end

    // bank is captured with the macro address, outputs are muxed after it
    always_ff @(posedge I_wb_clk) begin
        if (stb) begin
            bank_q <= bank;
        end
    end

    assign rdat = {dout_hi[bank_q], dout_lo[bank_q]};

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= stb;   // single cycle latency
        end
    end

endmodule

// ==== tests/mem_subsys_chk.sv ====
module mem_subsys_chk (
    input logic I_wb_clk,
    input logic rst_n,
    input logic stb,
    input logic ack,
    input logic spram_stb,
    input logic reg_stb
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;   // read by the testbench at the end

    // first cycle out of reset carries no ack
    ack_low_after_reset: assert property (@(posedge I_wb_clk) $rose(rst_n) |-> !ack)
        else begin
            fail_count++;
            $error("ack high in the first cycle after reset");
        end

    ack_follows_stb: assert property (@(posedge I_wb_clk) disable iff (!rst_n)
        $past(rst_n) |-> (ack == $past(stb)))
        else begin
            fail_count++;
            $error("ack does not match the strobe of the previous cycle");
        end

    one_target: assert property (@(posedge I_wb_clk) disable iff (!rst_n)
        !(spram_stb && reg_stb))
        else begin
            fail_count++;
            $error("decoder strobes SPRAM and register block together");
        end

endmodule

bind mem_subsys_top mem_subsys_chk i_mem_subsys_chk (
    .I_wb_clk  (I_wb_clk),
    .rst_n     (rst_n),
    .stb       (stb),
    .ack       (ack),
    .spram_stb (spram_stb),
    .reg_stb   (reg_stb)
);

// ==== tests/mem_subsys_tb.sv ====
module mem_subsys_tb
    import bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          RESET_CYCLES = 4;
    localparam int          ACK_WAIT     = 4;   // cycles before an access counts as lost
    localparam int          RANDOM_COUNT = 48;
    localparam logic [31:0] SEED         = 32'hf625_a766;
    localparam wb_addr_t    REG_BASE     = 16'h8000;

    // words written in full early on, the random section only touches these
    localparam wb_addr_t POOL [8] = '{16'h0000, 16'h0001, 16'h3fff, 16'h4000,
                                      16'h4001, 16'h7fff, 16'h1234, 16'h5234};

    logic     I_wb_clk;
    logic     rst_n;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_sel_t  sel;
    wb_data_t wdat;
    wb_data_t rdat;
    logic     ack;

    // stimulus table, one bus access per entry
    string    tab_name [$];
    logic     tab_we   [$];
    wb_addr_t tab_adr  [$];
    wb_sel_t  tab_sel  [$];
    wb_data_t tab_wdat [$];
    wb_data_t tab_exp  [$];

    wb_data_t    shadow_mem [int];   // SPRAM contents by word address
    wb_data_t    shadow_scratch;
    wb_data_t    shadow_wr;
    wb_data_t    shadow_rd;
    logic [31:0] rng_state;
    int          value_errors;
    int          handshake_errors;
    int          assert_errors;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    mem_subsys_top i_mem_subsys_top (
        .I_wb_clk (I_wb_clk),
        .rst_n    (rst_n),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .sel      (sel),
        .wdat     (wdat),
        .rdat     (rdat),
        .ack      (ack)
    );

    initial begin
        I_wb_clk = 1'b0;
        forever #2 I_wb_clk = ~I_wb_clk;
    end

    always @(posedge I_wb_clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run stopped after %0d cycles, the access table did not finish", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic wb_data_t merge_bytes(input wb_data_t old_word, input wb_data_t new_word,
                                             input wb_sel_t mask);
        wb_data_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // appends one access and works out its expected read data from the shadow state
    task automatic add_access(input string name, input logic wr, input wb_addr_t a,
                              input wb_sel_t s, input wb_data_t d);
        wb_data_t exp;
        int       key;
        exp = '0;
        key = int'(a[14:0]);
        if (!a[REGION_BIT]) begin
            if (wr) begin
                shadow_mem[key] = merge_bytes(shadow_mem.exists(key) ? shadow_mem[key] : '0, d, s);
                shadow_wr = shadow_wr + 32'd1;
            end else begin
                exp = shadow_mem[key];
                shadow_rd = shadow_rd + 32'd1;
            end
        end else begin
            case (a[1:0])
                REG_ID:       exp = ID_VALUE;   // writes are ignored
                REG_SCRATCH: begin
                    if (wr) begin
                        shadow_scratch = merge_bytes(shadow_scratch, d, s);
                    end
                    exp = shadow_scratch;
                end
                REG_WR_COUNT: exp = shadow_wr;
                REG_RD_COUNT: exp = shadow_rd;
            endcase
        end
        tab_name.push_back(name);
        tab_we.push_back(wr);
        tab_adr.push_back(a);
        tab_sel.push_back(s);
        tab_wdat.push_back(d);
        tab_exp.push_back(exp);
    endtask

    task automatic build_directed();
        add_access("scratch_reset", 1'b0, REG_BASE | 16'(REG_SCRATCH), 4'hf, '0);
        add_access("wr_count_reset", 1'b0, REG_BASE | 16'(REG_WR_COUNT), 4'hf, '0);
        add_access("rd_count_reset", 1'b0, REG_BASE | 16'(REG_RD_COUNT), 4'hf, '0);
        add_access("id_read", 1'b0, REG_BASE | 16'(REG_ID), 4'hf, '0);
        add_access("id_write", 1'b1, REG_BASE | 16'(REG_ID), 4'hf, 32'hdead_beef);
        add_access("id_after_write", 1'b0, REG_BASE | 16'(REG_ID), 4'hf, '0);
        for (int i = 0; i < 8; i++) begin
            add_access($sformatf("fill_%0d", i), 1'b1, POOL[i], 4'hf, {POOL[i], ~POOL[i]});
        end
        add_access("bank0_low", 1'b1, 16'h0010, 4'hf, 32'h1111_2222);
        add_access("bank1_low", 1'b1, 16'h4010, 4'hf, 32'h3333_4444);
        add_access("bank0_low_rd", 1'b0, 16'h0010, 4'hf, '0);
        add_access("bank1_low_rd", 1'b0, 16'h4010, 4'hf, '0);
        add_access("byte0_wr", 1'b1, 16'h0010, 4'b0001, 32'haabb_ccdd);
        add_access("byte0_rd", 1'b0, 16'h0010, 4'hf, '0);
        add_access("upper_half_wr", 1'b1, 16'h4010, 4'b1100, 32'h5566_7788);
        add_access("upper_half_rd", 1'b0, 16'h4010, 4'hf, '0);
        add_access("middle_wr", 1'b1, 16'h0010, 4'b0110, 32'h0f0f_0f0f);
        add_access("middle_rd", 1'b0, 16'h0010, 4'hf, '0);
        add_access("bank1_still", 1'b0, 16'h4010, 4'hf, '0);
        add_access("scratch_full_wr", 1'b1, REG_BASE | 16'(REG_SCRATCH), 4'hf, 32'h0123_4567);
        add_access("scratch_full_rd", 1'b0, REG_BASE | 16'(REG_SCRATCH), 4'hf, '0);
        add_access("scratch_mask_wr", 1'b1, 16'hfffd, 4'b1001, 32'hffee_ddcc);   // alias of idx 1
        add_access("scratch_mask_rd", 1'b0, REG_BASE | 16'(REG_SCRATCH), 4'hf, '0);
        add_access("wr_count_rd", 1'b0, REG_BASE | 16'(REG_WR_COUNT), 4'hf, '0);
        add_access("rd_count_rd", 1'b0, REG_BASE | 16'(REG_RD_COUNT), 4'hf, '0);
        add_access("wr_count_write", 1'b1, REG_BASE | 16'(REG_WR_COUNT), 4'hf, 32'h0000_0001);
        add_access("wr_count_again", 1'b0, REG_BASE | 16'(REG_WR_COUNT), 4'hf, '0);
    endtask

    task automatic build_random();
        logic [31:0] r;
        logic [31:0] d;
        wb_addr_t    a;
        reg_idx_t    idx;
        string       name;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r    = next_random();
            d    = next_random();
            a    = POOL[r[6:4]];
            idx  = r[12] ? REG_RD_COUNT : REG_WR_COUNT;
            name = $sformatf("rand_%0d", i);
            if (r[2:0] < 3'd3) begin
                add_access(name, 1'b1, a, r[11:8], d);
            end else if (r[2:0] < 3'd5) begin
                add_access(name, 1'b0, a, 4'hf, '0);
            end else if (r[2:0] == 3'd5) begin
                add_access(name, 1'b1, REG_BASE | 16'(REG_SCRATCH), r[11:8], d);
            end else if (r[2:0] == 3'd6) begin
                add_access(name, 1'b0, REG_BASE | 16'(REG_SCRATCH), 4'hf, '0);
            end else begin
                add_access(name, 1'b0, REG_BASE | 16'(idx), 4'hf, '0);
            end
        end
    endtask

    task automatic run_access(input int i);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        @(negedge I_wb_clk);
        assert (ack === 1'b0) else begin
            handshake_errors++;
            $display("%s: ack still high from the previous access", tab_name[i]);
        end
        stb  = 1'b1;
        we   = tab_we[i];
        adr  = tab_adr[i];
        sel  = tab_sel[i];
        wdat = tab_wdat[i];
        while (!seen && waited < ACK_WAIT) begin
            @(negedge I_wb_clk);
            waited++;
            seen = (ack === 1'b1);
        end
        assert (seen) else begin
            handshake_errors++;
            $display("%s: no ack within %0d cycles", tab_name[i], ACK_WAIT);
        end
        if (seen) begin
            assert (waited == 1) else begin
                handshake_errors++;
                $display("%s: ack took %0d cycles instead of 1", tab_name[i], waited);
            end
            if (!tab_we[i]) begin
                assert (rdat === tab_exp[i]) else begin
                    value_errors++;
                    $display("ERR %s: expected %h, actual %h", tab_name[i], tab_exp[i], rdat);
                end
            end
        end
        @(negedge I_wb_clk);   // stb stays up through the acking edge
        stb = 1'b0;
        we  = 1'b0;
    endtask

    initial begin
        stb              = 1'b0;
        we               = 1'b0;
        adr              = '0;
        sel              = '0;
        wdat             = '0;
        rst_n            = 1'b0;
        value_errors     = 0;
        handshake_errors = 0;
        rng_state        = SEED;
        shadow_scratch   = '0;
        shadow_wr        = '0;
        shadow_rd        = '0;
        build_directed();
        build_random();
        cycle_limit = 4 * tab_name.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge I_wb_clk);
        rst_n = 1'b1;
        assert (ack === 1'b0) else begin
            handshake_errors++;
            $display("ack is not low after reset");
        end
        for (int i = 0; i < tab_name.size(); i++) begin
            run_access(i);
        end
        @(negedge I_wb_clk);
        assert (ack === 1'b0) else begin
            handshake_errors++;
            $display("ack still high after the last access");
        end
        assert_errors = int'(i_mem_subsys_top.i_mem_subsys_chk.fail_count);
        $display("errors: %0d value, %0d handshake, %0d assertion",
                 value_errors, handshake_errors, assert_errors);
        if (value_errors + handshake_errors + assert_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
